// File: Bender.yml
package:
  name: decode_stage

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/decodePkg.sv
      - source/controlDecoder.sv
      - source/branchResolver.sv
      - source/decodeStage.sv
  - target: test
    include_dirs:
      - source
    files:
      - test/decodeStage_assert.sv
      - test/tbDecodeStage.sv

// File: flist.f
+incdir+source
source/decodePkg.sv
source/controlDecoder.sv
source/branchResolver.sv
source/decodeStage.sv
test/decodeStage_assert.sv
test/tbDecodeStage.sv

// File: source/branchResolver.sv
`timescale 1ns/1ps
`default_nettype none

module branchResolver (
    input  logic                 clk,
    input  logic                 arstN,
    input  logic                 midValid,
    input  decodePkg::decodedT   midData,
    output logic                 outValid,
    output decodePkg::decodeOutT outData
);

    decodePkg::fwdSelT rsSel;
    decodePkg::fwdSelT rtSel;
    decodePkg::wordT   rsOperand;
    decodePkg::wordT   rtOperand;
    decodePkg::wordT   branchOffset;
    decodePkg::wordT   target;
    logic              taken;

    ////////////////////////////////////////
    // forwarding select, mem beats wb
    function automatic decodePkg::fwdSelT selectFwd(
        input decodePkg::regAddrT   src,
        input decodePkg::fwdSourceT memStage,
        input decodePkg::fwdSourceT wbStage
    );
        if (memStage.regWrite && !memStage.memRead && memStage.dest == src) begin
            return decodePkg::fwdMem;
        end else if (wbStage.regWrite && wbStage.dest == src) begin
            return decodePkg::fwdWb; // also covers a load that reached wb
        end
        return decodePkg::fwdReg;
    endfunction

    function automatic decodePkg::wordT pickOperand(
        input decodePkg::fwdSelT sel,
        input decodePkg::wordT   regValue,
        input decodePkg::wordT   memValue,
        input decodePkg::wordT   wbValue
    );
        case (sel)
            decodePkg::fwdMem: return memValue;
            decodePkg::fwdWb:  return wbValue;
            default:           return regValue;
        endcase
    endfunction

    assign rsSel = selectFwd(midData.rs, midData.memStage, midData.wbStage);
    assign rtSel = selectFwd(midData.rt, midData.memStage, midData.wbStage);

    assign rsOperand = pickOperand(rsSel, midData.rsValue,
                                   midData.memStage.data, midData.wbStage.data);
    assign rtOperand = pickOperand(rtSel, midData.rtValue,
                                   midData.memStage.data, midData.wbStage.data);

    ////////////////////////////////////////
    // branch condition, signed against zero
    always_comb begin
        case (midData.branchKind)
            decodePkg::brBeq:     taken = (rsOperand == rtOperand);
            decodePkg::brBne:     taken = (rsOperand != rtOperand);
            decodePkg::brBlez:    taken = ($signed(rsOperand) <= 0);
            decodePkg::brBgtz:    taken = ($signed(rsOperand) > 0);
            decodePkg::brBltz,
            decodePkg::brBltzal:  taken = ($signed(rsOperand) < 0);
            decodePkg::brBgez,
            decodePkg::brBgezal:  taken = ($signed(rsOperand) >= 0);
            decodePkg::brRegJump: taken = 1'b1;
            default:              taken = 1'b0;
        endcase
    end

    // word offset to byte offset
    assign branchOffset = midData.imm << 2;
    assign target = (midData.branchKind == decodePkg::brRegJump) ?
                    rsOperand : midData.pcPlus4 + branchOffset;

    ////////////////////////////////////////
    // stage 2 register
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            outValid <= 1'b0;
            outData  <= '0;
        end else begin
            outValid <= midValid;
            if (midValid) begin
                outData <= '{
                    control:     midData.control,
                    rd:          midData.rd,
                    rt:          midData.rt,
                    shamt:       midData.shamt,
                    imm:         midData.imm,
                    operandA:    rsOperand,
                    operandB:    rtOperand,
                    branchTaken: taken,
                    target:      target
                };
            end
        end
    end

endmodule

`default_nettype wire

// File: source/controlDecoder.sv
`timescale 1ns/1ps
`include "decode_consts.svh"
`default_nettype none

module controlDecoder (
    input  logic                clk,
    input  logic                arstN,
    input  logic                inValid,
    input  decodePkg::decodeInT inData,
    output logic                midValid,
    output decodePkg::decodedT  midData
);

    decodePkg::opcodeT     opcode;
    decodePkg::functT      funct;
    decodePkg::regAddrT    rs;
    decodePkg::regAddrT    rt;
    decodePkg::regAddrT    rd;
    decodePkg::shamtT      shamt;
    decodePkg::wordT       imm;
    decodePkg::controlT    ctrl;
    decodePkg::branchKindT branchKind;

    ////////////////////////////////////////
    // field split
    assign opcode = inData.instr[31:26];
    assign rs     = inData.instr[25:21];
    assign rt     = inData.instr[20:16];
    assign rd     = inData.instr[15:11];
    assign shamt  = inData.instr[10:6];
    assign funct  = inData.instr[5:0];

    // logical immediates are sign-extended too
    assign imm = {{(`DATA_WIDTH-16){inData.instr[15]}}, inData.instr[15:0]};

    ////////////////////////////////////////
    // main control
    always_comb begin
        ctrl       = '0;
        ctrl.aluOp = decodePkg::aluNone;
        branchKind = decodePkg::brNone;
        case (opcode)
            `OPC_RTYPE: begin
                case (funct)
                    `FUNCT_SLL:               ctrl.aluOp = decodePkg::aluSll;
                    `FUNCT_SRL:               ctrl.aluOp = decodePkg::aluSrl;
                    `FUNCT_SRA:               ctrl.aluOp = decodePkg::aluSra;
                    `FUNCT_SLLV:              ctrl.aluOp = decodePkg::aluSllv;
                    `FUNCT_SRLV:              ctrl.aluOp = decodePkg::aluSrlv;
                    `FUNCT_SRAV:              ctrl.aluOp = decodePkg::aluSrav;
                    `FUNCT_JR, `FUNCT_JALR:   ctrl.aluOp = decodePkg::aluRegJump;
                    `FUNCT_ADD, `FUNCT_ADDU:  ctrl.aluOp = decodePkg::aluAdd;
                    `FUNCT_SUB, `FUNCT_SUBU:  ctrl.aluOp = decodePkg::aluSub;
                    `FUNCT_AND:               ctrl.aluOp = decodePkg::aluAnd;
                    `FUNCT_OR:                ctrl.aluOp = decodePkg::aluOr;
                    `FUNCT_XOR:               ctrl.aluOp = decodePkg::aluXor;
                    `FUNCT_NOR:               ctrl.aluOp = decodePkg::aluNor;
                    `FUNCT_SLT, `FUNCT_SLTU:  ctrl.aluOp = decodePkg::aluSlt;
                    default:                  ctrl.aluOp = decodePkg::aluNone;
                endcase
                if (ctrl.aluOp != decodePkg::aluNone) begin // known funct only
                    ctrl.regDst   = 1'b1;
                    ctrl.regWrite = (funct != `FUNCT_JR); // jr writes nothing
                    ctrl.link     = (funct == `FUNCT_JALR);
                    ctrl.shamtSel = (funct == `FUNCT_SLL) ||
                                    (funct == `FUNCT_SRL) ||
                                    (funct == `FUNCT_SRA);
                end
                if (ctrl.aluOp == decodePkg::aluRegJump) begin
                    branchKind = decodePkg::brRegJump;
                end
            end
            `OPC_REGIMM: begin
                case (rt)
                    `RT_BLTZ:   branchKind = decodePkg::brBltz;
                    `RT_BGEZ:   branchKind = decodePkg::brBgez;
                    `RT_BLTZAL: branchKind = decodePkg::brBltzal;
                    `RT_BGEZAL: branchKind = decodePkg::brBgezal;
                    default:    branchKind = decodePkg::brNone;
                endcase
                // al forms link even when not taken
                ctrl.link     = (branchKind == decodePkg::brBltzal) ||
                                (branchKind == decodePkg::brBgezal);
                ctrl.regWrite = ctrl.link;
            end
            `OPC_BEQ:  branchKind = decodePkg::brBeq;
            `OPC_BNE:  branchKind = decodePkg::brBne;
            `OPC_BLEZ: branchKind = decodePkg::brBlez;
            `OPC_BGTZ: branchKind = decodePkg::brBgtz;
            `OPC_ADDI, `OPC_ADDIU, `OPC_SLTI, `OPC_SLTIU,
            `OPC_ANDI, `OPC_ORI, `OPC_XORI, `OPC_LUI: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.regWrite = 1'b1; // dest is rt
                case (opcode)
                    `OPC_ADDI, `OPC_ADDIU: ctrl.aluOp = decodePkg::aluAdd;
                    `OPC_SLTI, `OPC_SLTIU: ctrl.aluOp = decodePkg::aluSlt;
                    `OPC_ANDI:             ctrl.aluOp = decodePkg::aluAnd;
                    `OPC_ORI:              ctrl.aluOp = decodePkg::aluOr;
                    `OPC_XORI:             ctrl.aluOp = decodePkg::aluXor;
                    default:               ctrl.aluOp = decodePkg::aluLui;
                endcase
            end
            `OPC_LW: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.memRead  = 1'b1;
                ctrl.memToReg = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = decodePkg::aluAdd; // base + offset
            end
            `OPC_SW: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.memWrite = 1'b1;
                ctrl.aluOp    = decodePkg::aluAdd;
            end
            default: ; // unknown opcode stays a bubble
        endcase
    end

    ////////////////////////////////////////
    // stage 1 register
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            midValid <= 1'b0;
            midData  <= '0;
        end else begin
            midValid <= inValid;
            if (inValid) begin
                midData <= '{
                    control:    ctrl,
                    branchKind: branchKind,
                    rs:         rs,
                    rt:         rt,
                    rd:         rd,
                    shamt:      shamt,
                    imm:        imm,
                    pcPlus4:    inData.pcPlus4,
                    rsValue:    inData.rsValue,
                    rtValue:    inData.rtValue,
                    memStage:   inData.memStage, // hazard context rides along
                    wbStage:    inData.wbStage
                };
            end
        end
    end

endmodule

`default_nettype wire

// File: source/decodePkg.sv
`default_nettype none

`include "decode_consts.svh"

package decodePkg;

    typedef logic [`DATA_WIDTH-1:0]     wordT;    // data word or address
    typedef logic [`REG_ADDR_WIDTH-1:0] regAddrT;
    typedef logic [5:0]                 opcodeT;
    typedef logic [5:0]                 functT;
    typedef logic [4:0]                 shamtT;

    // resolved ALU operation, same codes the EX stage already uses
    typedef enum logic [3:0] {
        aluAnd     = 4'd0,
        aluOr      = 4'd1,
        aluAdd     = 4'd2,
        aluXor     = 4'd3,
        aluSll     = 4'd4,
        aluSrl     = 4'd5,
        aluSub     = 4'd6,
        aluSlt     = 4'd7,
        aluSra     = 4'd8,
        aluSllv    = 4'd9,
        aluSrlv    = 4'd10,
        aluSrav    = 4'd11,
        aluNor     = 4'd12,
        aluLui     = 4'd13,
        aluRegJump = 4'd14, // jr / jalr
        aluNone    = 4'd15
    } aluOpT;

    typedef enum logic [3:0] {
        brNone,
        brBeq,
        brBne,
        brBlez,
        brBgtz,
        brBltz,
        brBgez,
        brBltzal,
        brBgezal,
        brRegJump
    } branchKindT;

    typedef enum logic [1:0] {
        fwdReg = 2'b00,
        fwdWb  = 2'b01,
        fwdMem = 2'b10
    } fwdSelT;

    ////////////////////////////////////////
    // one later pipeline stage, as seen from decode
    typedef struct packed {
        logic    regWrite;
        logic    memRead;
        regAddrT dest;
        wordT    data;
    } fwdSourceT;

    typedef struct packed {
        wordT      instr;
        wordT      pcPlus4;
        wordT      rsValue;
        wordT      rtValue;
        fwdSourceT memStage;
        fwdSourceT wbStage;
    } decodeInT;

    typedef struct packed {
        logic  regDst;
        logic  aluSrc;
        logic  memRead;
        logic  memWrite;
        logic  memToReg;
        logic  regWrite;
        logic  shamtSel; // shift by shamt field, not by rs
        logic  link;     // write return address
        aluOpT aluOp;
    } controlT;

    // stage 1 to stage 2
    typedef struct packed {
        controlT    control;
        branchKindT branchKind;
        regAddrT    rs;
        regAddrT    rt;
        regAddrT    rd;
        shamtT      shamt;
        wordT       imm;
        wordT       pcPlus4;
        wordT       rsValue;
        wordT       rtValue;
        fwdSourceT  memStage;
        fwdSourceT  wbStage;
    } decodedT;

    typedef struct packed {
        controlT control;
        regAddrT rd;
        regAddrT rt;
        shamtT   shamt;
        wordT    imm;
        wordT    operandA;
        wordT    operandB;
        logic    branchTaken;
        wordT    target;
    } decodeOutT;

endpackage

`default_nettype wire

// File: source/decodeStage.sv
`timescale 1ns/1ps
`default_nettype none

module decodeStage (
    input  logic                 clk,
    input  logic                 arstN,
    input  logic                 inValid,
    input  decodePkg::decodeInT  inData,
    output logic                 outValid,
    output decodePkg::decodeOutT outData
);

    logic               midValid;
    decodePkg::decodedT midData;

    // field split and control
    controlDecoder i_controlDecoder (
        .clk      (clk),
        .arstN    (arstN),
        .inValid  (inValid),
        .inData   (inData),
        .midValid (midValid),
        .midData  (midData)
    );

    // forwarding, compare and target
    branchResolver i_branchResolver (
        .clk      (clk),
        .arstN    (arstN),
        .midValid (midValid),
        .midData  (midData),
        .outValid (outValid),
        .outData  (outData)
    );

endmodule

`default_nettype wire

// File: source/decode_consts.svh
`ifndef DECODE_CONSTS_SVH
`define DECODE_CONSTS_SVH

`define DATA_WIDTH      32
`define REG_ADDR_WIDTH  5

////////////////////////////////////////
// opcodes, instr[31:26]
`define OPC_RTYPE   6'b000000
`define OPC_REGIMM  6'b000001 // rt field picks the branch
`define OPC_BEQ     6'b000100
`define OPC_BNE     6'b000101
`define OPC_BLEZ    6'b000110
`define OPC_BGTZ    6'b000111
`define OPC_ADDI    6'b001000
`define OPC_ADDIU   6'b001001
`define OPC_SLTI    6'b001010
`define OPC_SLTIU   6'b001011
`define OPC_ANDI    6'b001100
`define OPC_ORI     6'b001101
`define OPC_XORI    6'b001110
`define OPC_LUI     6'b001111
`define OPC_LW      6'b100011
`define OPC_SW      6'b101011

////////////////////////////////////////
// funct codes, instr[5:0] of R-type
`define FUNCT_SLL   6'b000000
`define FUNCT_SRL   6'b000010
`define FUNCT_SRA   6'b000011
`define FUNCT_SLLV  6'b000100
`define FUNCT_SRLV  6'b000110
`define FUNCT_SRAV  6'b000111
`define FUNCT_JR    6'b001000
`define FUNCT_JALR  6'b001001
`define FUNCT_ADD   6'b100000
`define FUNCT_ADDU  6'b100001
`define FUNCT_SUB   6'b100010
`define FUNCT_SUBU  6'b100011
`define FUNCT_AND   6'b100100
`define FUNCT_OR    6'b100101
`define FUNCT_XOR   6'b100110
`define FUNCT_NOR   6'b100111
`define FUNCT_SLT   6'b101010
`define FUNCT_SLTU  6'b101011

////////////////////////////////////////
// regimm rt codes
`define RT_BLTZ     5'b00000
`define RT_BGEZ     5'b00001
`define RT_BLTZAL   5'b10000
`define RT_BGEZAL   5'b10001

`endif

// File: test/decodeStage_assert.sv
`timescale 1ns/1ps
`default_nettype none

module decodeStageAssert (
    input logic                 clk,
    input logic                 arstN,
    input logic                 inValid,
    input logic                 outValid,
    input decodePkg::decodeOutT outData
);

    int failCount = 0; // read by the testbench at the end

    quietInReset: assert property (@(posedge clk) !arstN |-> !outValid)
        else begin
            failCount++;
            $error("outValid high while arstN is low");
        end

    // two register stages, no stall
    fixedLatency: assert property (@(posedge clk) disable iff (!arstN)
                                   outValid == $past(inValid, 2))
        else begin
            failCount++;
            $error("outValid does not follow inValid by two cycles");
        end

    memExclusive: assert property (@(posedge clk)
                                   !(outData.control.memRead && outData.control.memWrite))
        else begin
            failCount++;
            $error("memRead and memWrite both high");
        end

endmodule

bind decodeStage decodeStageAssert i_decodeStageAssert (
    .clk      (clk),
    .arstN    (arstN),
    .inValid  (inValid),
    .outValid (outValid),
    .outData  (outData)
);

`default_nettype wire

// File: test/tbDecodeStage.sv
`timescale 1ns/1ps
`include "decode_consts.svh"
`default_nettype none

module tbDecodeStage;

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 3;
    localparam int NUM_TESTS    = 400;
    localparam int LATENCY      = 2;

    logic                 clk;
    logic                 arstN;
    logic                 inValid;
    decodePkg::decodeInT  inData;
    logic                 outValid;
    decodePkg::decodeOutT outData;

    integer seed = 32'hc534_d80c;
    int     cycle = 0;

    decodePkg::decodeOutT expQ[$];
    int                   sendQ[$]; // cycle in which each beat was driven

    ////////////////////////////////////////
    // instruction tables, one aluOp per entry
    decodePkg::functT rFuncts [18] = '{`FUNCT_SLL, `FUNCT_SRL, `FUNCT_SRA, `FUNCT_SLLV,
        `FUNCT_SRLV, `FUNCT_SRAV, `FUNCT_JR, `FUNCT_JALR, `FUNCT_ADD, `FUNCT_ADDU,
        `FUNCT_SUB, `FUNCT_SUBU, `FUNCT_AND, `FUNCT_OR, `FUNCT_XOR, `FUNCT_NOR,
        `FUNCT_SLT, `FUNCT_SLTU};
    decodePkg::aluOpT rOps [18] = '{decodePkg::aluSll, decodePkg::aluSrl, decodePkg::aluSra,
        decodePkg::aluSllv, decodePkg::aluSrlv, decodePkg::aluSrav, decodePkg::aluRegJump,
        decodePkg::aluRegJump, decodePkg::aluAdd, decodePkg::aluAdd, decodePkg::aluSub,
        decodePkg::aluSub, decodePkg::aluAnd, decodePkg::aluOr, decodePkg::aluXor,
        decodePkg::aluNor, decodePkg::aluSlt, decodePkg::aluSlt};
    decodePkg::opcodeT iOpcodes [10] = '{`OPC_ADDI, `OPC_ADDIU, `OPC_SLTI, `OPC_SLTIU,
        `OPC_ANDI, `OPC_ORI, `OPC_XORI, `OPC_LUI, `OPC_LW, `OPC_SW};
    decodePkg::aluOpT iOps [10] = '{decodePkg::aluAdd, decodePkg::aluAdd, decodePkg::aluSlt,
        decodePkg::aluSlt, decodePkg::aluAnd, decodePkg::aluOr, decodePkg::aluXor,
        decodePkg::aluLui, decodePkg::aluAdd, decodePkg::aluAdd};
    decodePkg::opcodeT  brOpcodes [4] = '{`OPC_BEQ, `OPC_BNE, `OPC_BLEZ, `OPC_BGTZ};
    decodePkg::regAddrT regimmRts [4] = '{`RT_BLTZ, `RT_BGEZ, `RT_BLTZAL, `RT_BGEZAL};

    decodeStage i_decodeStage (
        .clk      (clk),
        .arstN    (arstN),
        .inValid  (inValid),
        .inData   (inData),
        .outValid (outValid),
        .outData  (outData)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) cycle <= cycle + 1;

    ////////////////////////////////////////
    // reference model
    function automatic decodePkg::controlT expectedControl(input decodePkg::wordT instr);
        decodePkg::controlT c;
        int i;
        c = '0;
        c.aluOp = decodePkg::aluNone;
        if (instr[31:26] == `OPC_RTYPE) begin
            for (i = 0; i < 18; i++) begin
                if (rFuncts[i] == instr[5:0]) begin
                    c.aluOp    = rOps[i];
                    c.regDst   = 1'b1;
                    c.regWrite = (instr[5:0] != `FUNCT_JR);
                    c.link     = (instr[5:0] == `FUNCT_JALR);
                    c.shamtSel = (i < 3); // sll, srl, sra head the table
                end
            end
        end else if (instr[31:26] == `OPC_REGIMM) begin
            c.link     = instr[20]; // al forms have rt bit 4 set
            c.regWrite = instr[20];
        end
        for (i = 0; i < 10; i++) begin
            if (iOpcodes[i] == instr[31:26]) begin
                c.aluOp    = iOps[i];
                c.aluSrc   = 1'b1;
                c.memRead  = (i == 8);
                c.memToReg = (i == 8);
                c.memWrite = (i == 9);
                c.regWrite = (i != 9);
            end
        end
        return c;
    endfunction

    function automatic decodePkg::wordT forwarded(input decodePkg::regAddrT src,
                                                  input decodePkg::wordT regValue,
                                                  input decodePkg::decodeInT d);
        if (d.memStage.regWrite && !d.memStage.memRead && d.memStage.dest == src) begin
            return d.memStage.data;
        end
        if (d.wbStage.regWrite && d.wbStage.dest == src) begin
            return d.wbStage.data;
        end
        return regValue;
    endfunction

    function automatic decodePkg::decodeOutT expectedDecode(input decodePkg::decodeInT d);
        decodePkg::decodeOutT e;
        logic signed [31:0]   a;
        e          = '0;
        e.control  = expectedControl(d.instr);
        e.rd       = d.instr[15:11];
        e.rt       = d.instr[20:16];
        e.shamt    = d.instr[10:6];
        e.imm      = {{16{d.instr[15]}}, d.instr[15:0]};
        e.operandA = forwarded(d.instr[25:21], d.rsValue, d);
        e.operandB = forwarded(d.instr[20:16], d.rtValue, d);
        e.target   = d.pcPlus4 + (e.imm << 2);
        a          = e.operandA;
        case (d.instr[31:26])
            `OPC_BEQ:    e.branchTaken = (e.operandA == e.operandB);
            `OPC_BNE:    e.branchTaken = (e.operandA != e.operandB);
            `OPC_BLEZ:   e.branchTaken = (a <= 0);
            `OPC_BGTZ:   e.branchTaken = (a > 0);
            `OPC_REGIMM: e.branchTaken = d.instr[16] ? (a >= 0) : (a < 0); // rt bit 0 is gez
            default:     e.branchTaken = 1'b0;
        endcase
        if (e.control.aluOp == decodePkg::aluRegJump) begin
            e.branchTaken = 1'b1;
            e.target      = e.operandA;
        end
        return e;
    endfunction

    ////////////////////////////////////////
    // stimulus
    function automatic decodePkg::wordT pickValue();
        case ($unsigned($random(seed)) % 4)
            0:       return '0;
            1:       return 1 + $unsigned($random(seed)) % 100;
            2:       return ~($unsigned($random(seed)) % 100); // -1 down to -100
            default: return $random(seed);
        endcase
    endfunction

    function automatic decodePkg::fwdSourceT randomSource();
        decodePkg::fwdSourceT s;
        s.regWrite = ($unsigned($random(seed)) % 4 != 0);
        s.memRead  = ($unsigned($random(seed)) % 4 == 0); // load blocks the mem path
        s.dest     = decodePkg::regAddrT'($unsigned($random(seed)) % 4);
        s.data     = pickValue();
        return s;
    endfunction

    task automatic randomBeat(output decodePkg::decodeInT d);
        int pick;
        pick = $unsigned($random(seed)) % 36;
        d = '0;
        d.instr = $random(seed);
        d.instr[25:21] = decodePkg::regAddrT'($unsigned($random(seed)) % 4); // few regs
        d.instr[20:16] = decodePkg::regAddrT'($unsigned($random(seed)) % 4);
        if (pick < 18) begin
            d.instr[31:26] = `OPC_RTYPE;
            d.instr[5:0]   = rFuncts[pick];
        end else if (pick < 28) begin
            d.instr[31:26] = iOpcodes[pick - 18];
        end else if (pick < 32) begin
            d.instr[31:26] = brOpcodes[pick - 28];
        end else begin
            d.instr[31:26] = `OPC_REGIMM;
            d.instr[20:16] = regimmRts[pick - 32];
        end
        d.pcPlus4  = $random(seed) & 32'hffff_fffc;
        d.rsValue  = pickValue();
        d.rtValue  = ($unsigned($random(seed)) % 4 == 0) ? d.rsValue : pickValue();
        d.memStage = randomSource();
        d.wbStage  = randomSource();
    endtask

    ////////////////////////////////////////
    // checking
    task automatic reportFailure(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic checkControl(input decodePkg::controlT got, input decodePkg::controlT exp);
        if (got !== exp) begin
            reportFailure($sformatf("error at %0t: control is %h, expected %h",
                                    $time, got, exp));
        end
    endtask

    task automatic checkWord(input string name, input decodePkg::wordT got,
                             input decodePkg::wordT exp);
        if (got !== exp) begin
            reportFailure($sformatf("error at %0t: %s is %h, expected %h",
                                    $time, name, got, exp));
        end
    endtask

    task automatic checkReg(input string name, input decodePkg::regAddrT got,
                            input decodePkg::regAddrT exp);
        if (got !== exp) begin
            reportFailure($sformatf("error at %0t: %s is %0d, expected %0d",
                                    $time, name, got, exp));
        end
    endtask

    task automatic checkShamt(input decodePkg::shamtT got, input decodePkg::shamtT exp);
        if (got !== exp) begin
            reportFailure($sformatf("error at %0t: shamt is %0d, expected %0d",
                                    $time, got, exp));
        end
    endtask

    task automatic checkBit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            reportFailure($sformatf("error at %0t: %s is %b, expected %b",
                                    $time, name, got, exp));
        end
    endtask

    always @(negedge clk) begin : compareOutputs
        decodePkg::decodeOutT exp;
        int                   sent;
        if (!arstN && outValid) begin
            reportFailure("outValid went high while reset was held");
        end else if (outValid && expQ.size() == 0) begin
            reportFailure("an output beat came out with no beat pending");
        end else if (outValid) begin
            exp  = expQ.pop_front();
            sent = sendQ.pop_front();
            if (cycle != sent + LATENCY) begin
                reportFailure($sformatf("beat driven in cycle %0d came out in cycle %0d",
                                        sent, cycle));
            end
            checkControl(outData.control, exp.control);
            checkReg("rd", outData.rd, exp.rd);
            checkReg("rt", outData.rt, exp.rt);
            checkShamt(outData.shamt, exp.shamt);
            checkWord("imm", outData.imm, exp.imm);
            checkWord("operandA", outData.operandA, exp.operandA);
            checkWord("operandB", outData.operandB, exp.operandB);
            checkBit("branchTaken", outData.branchTaken, exp.branchTaken);
            checkWord("target", outData.target, exp.target);
        end
    end

    ////////////////////////////////////////
    // main sequence
    initial begin
        decodePkg::decodeInT beat;
        int                  n;
        clk     = 1'b0;
        arstN   = 1'b0;
        inValid = 1'b0;
        inData  = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #0.5 arstN = 1'b1;
        for (n = 0; n < NUM_TESTS; n++) begin
            @(posedge clk);
            #0.5;
            if ($unsigned($random(seed)) % 5 == 0) begin
                inValid = 1'b0; // gap
            end else begin
                randomBeat(beat);
                inValid = 1'b1;
                inData  = beat;
                expQ.push_back(expectedDecode(beat));
                sendQ.push_back(cycle);
            end
        end
        @(posedge clk);
        #0.5 inValid = 1'b0;
        repeat (LATENCY + 2) @(negedge clk);
        if (expQ.size() == 0 && i_decodeStage.i_decodeStageAssert.failCount == 0) begin
            $display("TEST OK");
            $finish;
        end else begin
            reportFailure($sformatf("%0d beats never came out, %0d assertion failures",
                          expQ.size(), i_decodeStage.i_decodeStageAssert.failCount));
        end
    end

    initial begin
        #((RESET_CYCLES + NUM_TESTS * 2 + 20) * CLK_PERIOD);
        $display("timeout: the run did not finish in the expected time");
        $display("TEST FAILED");
        $fatal(1);
    end

endmodule

`default_nettype wire
